//--- rtl/calib_defs.svh
`ifndef CALIB_DEFS_SVH
`define CALIB_DEFS_SVH

// **************************************************
// frame geometry
// **************************************************
`define CALIB_ACTIVE_H_PIXELS 1280
`define CALIB_ACTIVE_LINES 720
`define CALIB_DOWNSAMPLE_SHIFT 2 // log2 of block side.

// **************************************************
// step timing and word sizes
// **************************************************
`define CALIB_WAIT_CYCLES 10000000 // camera settle time.
`define CALIB_LED_ADDRESS_WIDTH 10
`define CALIB_REQ_ADDR_WIDTH 20 // covers 320x180 words.
`define CALIB_COUNTER_WIDTH(n) (((n) > 1) ? $clog2(n) : 1)

// default luma thresholds.
`define CALIB_LOW_THRESH 8'd64
`define CALIB_HIGH_THRESH 8'd192

`endif

//--- rtl/calib_pkg.sv
`default_nettype none

`include "calib_defs.svh"

package calib_pkg;

    // **************************************************
    // calibration step sequencing
    // **************************************************
    typedef enum logic [1:0] {
        IDLE            = 2'd0,
        WAIT_FOR_CAM    = 2'd1,
        WAIT_FOR_NFRAME = 2'd2,
        CAPTURE_FRAME   = 2'd3
    } calibration_step_state_t;

    // **************************************************
    // accumulate memory requests
    // **************************************************
    typedef enum logic [1:0] {
        READ       = 2'd0, // return word as is.
        WRITE      = 2'd1, // shift left, summand into bit 0.
        WRITE_OVER = 2'd2, // replace with summand.
        DISABLE    = 2'd3  // no change, no result.
    } accum_request_t;

    typedef logic [`CALIB_REQ_ADDR_WIDTH-1:0] accum_addr_t;

    typedef struct packed {
        accum_request_t request_type;
        logic           summand;
        accum_addr_t    addr;
    } accum_req_t;

endpackage

`default_nettype wire

//--- rtl/pixel_detect.sv
`default_nettype none

module pixel_detect (
    input  wire         clk_pixel,
    input  wire         rst,
    input  wire  [7:0]  luma,
    input  wire  [7:0]  low_thresh,
    input  wire  [7:0]  high_thresh,
    input  wire  [10:0] hcount_in,
    input  wire  [9:0]  vcount_in,
    input  wire         new_frame_in,
    input  wire         read_request,
    output logic        detect_0,
    output logic        detect_1,
    output logic [10:0] hcount_out,
    output logic [9:0]  vcount_out,
    output logic        new_frame_out,
    output logic        read_request_out
);

    logic is_dark;
    logic is_lit;

    assign is_dark = luma < low_thresh;
    assign is_lit  = luma >= high_thresh;

    // decisions and position travel together.
    always_ff @(posedge clk_pixel) begin
        detect_0   <= is_dark;
        detect_1   <= is_lit;
        hcount_out <= hcount_in;
        vcount_out <= vcount_in;
    end

    always_ff @(posedge clk_pixel) begin
        if (rst) begin
            new_frame_out    <= 1'b0;
            read_request_out <= 1'b0;
        end else begin
            new_frame_out    <= new_frame_in;
            read_request_out <= read_request;
        end
    end

    // overlapping bands would flag one pixel both lit and dark.
    thresh_order_a: assert property (
        @(posedge clk_pixel) disable iff (rst)
        low_thresh <= high_thresh
    ) else $error("pixel_detect: low_thresh above high_thresh");

endmodule

`default_nettype wire

//--- rtl/calibration_step_fsm.sv
`default_nettype none

`include "calib_defs.svh"

module calibration_step_fsm #(
    parameter int ACTIVE_H_PIXELS = `CALIB_ACTIVE_H_PIXELS,
    parameter int ACTIVE_LINES    = `CALIB_ACTIVE_LINES,
    parameter int WAIT_CYCLES     = `CALIB_WAIT_CYCLES
) (
    input  wire                                    clk_pixel,
    input  wire                                    rst,
    input  wire                                    start_calibration_step,
    input  wire                                    should_overwrite_latch,
    input  wire                                    read_request,
    input  wire  [10:0]                            hcount_in,
    input  wire  [9:0]                             vcount_in,
    input  wire                                    new_frame_in,
    input  wire                                    detect_0,
    input  wire                                    detect_1,
    output logic                                   should_overwrite,
    output calib_pkg::calibration_step_state_t     state,
    output logic [`CALIB_COUNTER_WIDTH(WAIT_CYCLES)-1:0] wait_counter,
    output calib_pkg::accum_req_t                  req,
    output logic                                   req_valid
);

    import calib_pkg::*;

    localparam int DS      = `CALIB_DOWNSAMPLE_SHIFT;
    localparam int H_WORDS = ACTIVE_H_PIXELS >> DS;

    logic        in_active;
    logic        block_corner;
    logic        capture_hit;
    accum_addr_t pixel_addr;

    // **************************************************
    // step sequencing
    // **************************************************
    always_ff @(posedge clk_pixel) begin
        if (rst) begin
            state        <= IDLE;
            wait_counter <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_calibration_step) begin // level, sampled here only.
                        state        <= WAIT_FOR_CAM;
                        wait_counter <= '0;
                    end
                end
                WAIT_FOR_CAM: begin
                    if (wait_counter == WAIT_CYCLES - 1) begin
                        state        <= WAIT_FOR_NFRAME;
                        wait_counter <= '0;
                    end else begin
                        wait_counter <= wait_counter + 1'b1;
                    end
                end
                WAIT_FOR_NFRAME: begin
                    if (new_frame_in) begin
                        state <= CAPTURE_FRAME;
                    end
                end
                CAPTURE_FRAME: begin
                    if (new_frame_in) begin // one whole frame captured.
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // sticky until the first capture frame ends.
    always_ff @(posedge clk_pixel) begin
        if (rst) begin
            should_overwrite <= 1'b0;
        end else if ((state == CAPTURE_FRAME) && new_frame_in) begin
            should_overwrite <= 1'b0;
        end else if (should_overwrite_latch) begin
            should_overwrite <= 1'b1;
        end
    end

    // **************************************************
    // memory requests
    // **************************************************
    assign in_active    = (hcount_in < ACTIVE_H_PIXELS) && (vcount_in < ACTIVE_LINES);
    assign block_corner = (hcount_in[DS-1:0] == '0) && (vcount_in[DS-1:0] == '0);
    assign capture_hit  = (state == CAPTURE_FRAME) && in_active && block_corner;

    // row times width plus column.
    assign pixel_addr = accum_addr_t'(vcount_in >> DS) * accum_addr_t'(H_WORDS)
                      + accum_addr_t'(hcount_in >> DS);

    always_comb begin
        req.addr         = pixel_addr;
        req.summand      = detect_1;
        req.request_type = READ;
        if (capture_hit) begin
            if (detect_0 == detect_1) begin // both or neither.
                req.request_type = DISABLE;
            end else if (should_overwrite) begin
                req.request_type = WRITE_OVER;
            end else begin
                req.request_type = WRITE;
            end
        end
    end

    assign req_valid = read_request || capture_hit;

    // capture always follows the wait for a frame edge.
    capture_entry_a: assert property (
        @(posedge clk_pixel) disable iff (rst)
        $rose(state == CAPTURE_FRAME) |-> ($past(state) == WAIT_FOR_NFRAME)
    ) else $error("calibration_step_fsm: CAPTURE_FRAME entered from wrong state");

endmodule

`default_nettype wire

//--- rtl/shift_accum_ram.sv
`default_nettype none

module shift_accum_ram #(
    parameter int WIDTH = 10,
    parameter int DEPTH = 57600
) (
    input  wire                   clk_pixel,
    input  wire                   rst,
    input  wire calib_pkg::accum_req_t req,
    input  wire                   req_valid,
    output logic [WIDTH-1:0]      read_out,
    output logic                  read_valid
);

    import calib_pkg::*;

    localparam int INDEX_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];

    accum_req_t       s1_req;
    logic             s1_valid;
    logic [WIDTH-1:0] s1_word;
    logic [WIDTH-1:0] s1_result;
    logic             s1_writes;
    logic             s1_gives_result;
    logic             forward_hit;

    // **************************************************
    // modify
    // **************************************************
    always_comb begin
        case (s1_req.request_type)
            WRITE:      s1_result = (s1_word << 1) | WIDTH'(s1_req.summand);
            WRITE_OVER: s1_result = WIDTH'(s1_req.summand);
            default:    s1_result = s1_word; // READ and DISABLE.
        endcase
    end

    assign s1_writes = s1_valid
                     && ((s1_req.request_type == WRITE) || (s1_req.request_type == WRITE_OVER));
    assign s1_gives_result = s1_valid && (s1_req.request_type != DISABLE);

    // word being written this edge is newer than the array.
    assign forward_hit = s1_writes && (s1_req.addr == req.addr);

    // **************************************************
    // read stage
    // **************************************************
    always_ff @(posedge clk_pixel) begin
        s1_req  <= req;
        s1_word <= forward_hit ? s1_result : mem[INDEX_WIDTH'(req.addr)];
    end

    // **************************************************
    // write stage
    // **************************************************
    always_ff @(posedge clk_pixel) begin
        if (s1_writes) begin
            mem[INDEX_WIDTH'(s1_req.addr)] <= s1_result;
        end
        if (s1_gives_result) begin
            read_out <= s1_result;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (rst) begin
            s1_valid   <= 1'b0;
            read_valid <= 1'b0;
        end else begin
            s1_valid   <= req_valid;
            read_valid <= s1_gives_result;
        end
    end

    req_in_range_a: assert property (
        @(posedge clk_pixel) disable iff (rst)
        req_valid |-> (req.addr < DEPTH)
    ) else $error("shift_accum_ram: request address beyond DEPTH");

endmodule

`default_nettype wire

//--- rtl/calib_capture_top.sv
`default_nettype none

`include "calib_defs.svh"

module calib_capture_top #(
    parameter int ACTIVE_H_PIXELS   = `CALIB_ACTIVE_H_PIXELS,
    parameter int ACTIVE_LINES      = `CALIB_ACTIVE_LINES,
    parameter int WAIT_CYCLES       = `CALIB_WAIT_CYCLES,
    parameter int LED_ADDRESS_WIDTH = `CALIB_LED_ADDRESS_WIDTH
) (
    input  wire                                    clk_pixel,
    input  wire                                    rst,
    input  wire  [7:0]                             luma,
    input  wire  [10:0]                            hcount_in,
    input  wire  [9:0]                             vcount_in,
    input  wire                                    new_frame_in,
    input  wire  [7:0]                             low_thresh,
    input  wire  [7:0]                             high_thresh,
    input  wire                                    start_calibration_step,
    input  wire                                    should_overwrite_latch,
    input  wire                                    read_request,
    output calib_pkg::calibration_step_state_t     state,
    output logic                                   should_overwrite,
    output logic [`CALIB_COUNTER_WIDTH(WAIT_CYCLES)-1:0] wait_counter,
    output logic [LED_ADDRESS_WIDTH-1:0]           read_out,
    output logic                                   read_valid
);

    import calib_pkg::*;

    localparam int DS    = `CALIB_DOWNSAMPLE_SHIFT;
    localparam int DEPTH = (ACTIVE_H_PIXELS >> DS) * (ACTIVE_LINES >> DS); // one word per block.

    logic        detect_0;
    logic        detect_1;
    logic [10:0] hcount_d;
    logic [9:0]  vcount_d;
    logic        new_frame_d;
    logic        read_request_d;
    accum_req_t  req;
    logic        req_valid;

    pixel_detect i_pixel_detect (
        .clk_pixel        (clk_pixel),
        .rst              (rst),
        .luma             (luma),
        .low_thresh       (low_thresh),
        .high_thresh      (high_thresh),
        .hcount_in        (hcount_in),
        .vcount_in        (vcount_in),
        .new_frame_in     (new_frame_in),
        .read_request     (read_request),
        .detect_0         (detect_0),
        .detect_1         (detect_1),
        .hcount_out       (hcount_d),
        .vcount_out       (vcount_d),
        .new_frame_out    (new_frame_d),
        .read_request_out (read_request_d)
    );

    calibration_step_fsm #(
        .ACTIVE_H_PIXELS (ACTIVE_H_PIXELS),
        .ACTIVE_LINES    (ACTIVE_LINES),
        .WAIT_CYCLES     (WAIT_CYCLES)
    ) i_step_fsm (
        .clk_pixel              (clk_pixel),
        .rst                    (rst),
        .start_calibration_step (start_calibration_step),
        .should_overwrite_latch (should_overwrite_latch),
        .read_request           (read_request_d),
        .hcount_in              (hcount_d),
        .vcount_in              (vcount_d),
        .new_frame_in           (new_frame_d),
        .detect_0               (detect_0),
        .detect_1               (detect_1),
        .should_overwrite       (should_overwrite),
        .state                  (state),
        .wait_counter           (wait_counter),
        .req                    (req),
        .req_valid              (req_valid)
    );

    shift_accum_ram #(
        .WIDTH (LED_ADDRESS_WIDTH),
        .DEPTH (DEPTH)
    ) i_accum_ram (
        .clk_pixel  (clk_pixel),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .read_out   (read_out),
        .read_valid (read_valid)
    );

endmodule

`default_nettype wire

//--- tests/tb_calib_capture.sv
`default_nettype none

`include "calib_defs.svh"

module tb_calib_capture;

    timeunit 1ns;
    timeprecision 100ps;

    import calib_pkg::*;

    localparam int H_PIXELS     = 32;
    localparam int V_LINES      = 16;
    localparam int WAIT_CYCLES  = 20;
    localparam int WORD_WIDTH   = 4;
    localparam int DS           = `CALIB_DOWNSAMPLE_SHIFT;
    localparam int H_BLOCKS     = H_PIXELS >> DS;
    localparam int N_BLOCKS     = H_BLOCKS * (V_LINES >> DS);
    localparam int FRAME_CYCLES = H_PIXELS * V_LINES;
    localparam int MAX_CYCLES   = 4 * (WAIT_CYCLES + 3 * FRAME_CYCLES) + 8 * N_BLOCKS + 200;
    localparam logic [7:0] DARK_LUMA   = 8'd16;
    localparam logic [7:0] GRAY_LUMA   = 8'd128; // between the thresholds.
    localparam logic [7:0] BRIGHT_LUMA = 8'd240;

    logic                    clk_pixel = 1'b0;
    logic                    rst;
    logic [7:0]              luma;
    logic [10:0]             hcount_in;
    logic [9:0]              vcount_in;
    logic                    new_frame_in;
    logic [7:0]              low_thresh;
    logic [7:0]              high_thresh;
    logic                    start_calibration_step;
    logic                    should_overwrite_latch;
    logic                    read_request;
    calibration_step_state_t state;
    logic                    should_overwrite;
    logic [`CALIB_COUNTER_WIDTH(WAIT_CYCLES)-1:0] wait_counter;
    logic [WORD_WIDTH-1:0]   read_out;
    logic                    read_valid;

    logic [3:0] codes [N_BLOCKS];
    logic       gray_block [N_BLOCKS];
    logic [3:0] exp_q [$];
    int         due_q [$];
    int         cycle = 0;
    int         cam_cycles = 0;
    int         capture_pulses = 0;
    logic       new_frame_d;
    logic       read_phase = 1'b0;

    always #4 clk_pixel = ~clk_pixel; // 8 ns period.

    calib_capture_top #(
        .ACTIVE_H_PIXELS   (H_PIXELS),
        .ACTIVE_LINES      (V_LINES),
        .WAIT_CYCLES       (WAIT_CYCLES),
        .LED_ADDRESS_WIDTH (WORD_WIDTH)
    ) i_dut (
        .clk_pixel              (clk_pixel),
        .rst                    (rst),
        .luma                   (luma),
        .hcount_in              (hcount_in),
        .vcount_in              (vcount_in),
        .new_frame_in           (new_frame_in),
        .low_thresh             (low_thresh),
        .high_thresh            (high_thresh),
        .start_calibration_step (start_calibration_step),
        .should_overwrite_latch (should_overwrite_latch),
        .read_request           (read_request),
        .state                  (state),
        .should_overwrite       (should_overwrite),
        .wait_counter           (wait_counter),
        .read_out               (read_out),
        .read_valid             (read_valid)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        fail_now($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, want));
    endtask

    task automatic next_cycle();
        @(posedge clk_pixel);
        #1;
    endtask

    // accumulate rules with step 2 skipped for gray blocks.
    function automatic logic [3:0] expected_word(input logic [3:0] code, input logic gray);
        logic [3:0] word;
        word = {3'b000, code[3]};
        for (int k = 1; k < 4; k++) begin
            if (!(gray && k == 2)) word = {word[2:0], code[3-k]};
        end
        return word;
    endfunction

    function automatic logic [7:0] scene_luma(input int blk, input int step);
        if (step == 2 && gray_block[blk]) return GRAY_LUMA;
        return codes[blk][3-step] ? BRIGHT_LUMA : DARK_LUMA;
    endfunction

    // **************************************************
    // stimulus
    // **************************************************
    task automatic drive_frame(input int step);
        int blk;
        for (int v = 0; v < V_LINES; v++) begin
            for (int h = 0; h < H_PIXELS; h++) begin
                blk          = (v >> DS) * H_BLOCKS + (h >> DS);
                hcount_in    = 11'(h);
                vcount_in    = 10'(v);
                new_frame_in = (h == 0) && (v == 0);
                luma         = scene_luma(blk, step);
                next_cycle();
            end
        end
        new_frame_in = 1'b0;
    endtask

    task automatic run_step(input int step);
        int frames;
        int writes;
        int pulses_before;
        frames        = 0;
        writes        = 0;
        pulses_before = capture_pulses;
        for (int b = 0; b < N_BLOCKS; b++) begin
            if (!(step == 2 && gray_block[b])) writes++;
        end
        start_calibration_step = 1'b1;
        next_cycle();
        start_calibration_step = 1'b0;
        do begin
            drive_frame(step); // settle, wait for frame, capture.
            frames++;
        end while (state != IDLE && frames < 4);
        assert (state == IDLE && frames == 3)
            else fail_now($sformatf("step %0d did not return to IDLE after three frames", step));
        assert (capture_pulses - pulses_before == writes)
            else value_mismatch("capture read_valid count", capture_pulses - pulses_before, writes);
    endtask

    task automatic read_block(input int blk);
        read_request = 1'b1;
        hcount_in    = 11'((blk % H_BLOCKS) << DS);
        vcount_in    = 10'((blk / H_BLOCKS) << DS);
        exp_q.push_back(expected_word(codes[blk], gray_block[blk]));
        next_cycle();
        read_request = 1'b0;
    endtask

    // **************************************************
    // monitors and checks
    // **************************************************
    always @(posedge clk_pixel) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) fail_now("timeout: run did not finish in time");
    end

    always @(posedge clk_pixel) begin
        new_frame_d <= rst ? 1'b0 : new_frame_in; // frame edge as the FSM sees it.
        if (rst) begin
            cam_cycles <= 0;
        end else if (state == WAIT_FOR_CAM) begin
            assert (int'(wait_counter) == cam_cycles)
                else value_mismatch("wait_counter", wait_counter, cam_cycles);
            cam_cycles <= cam_cycles + 1;
        end else begin
            if (cam_cycles != 0) begin
                assert (cam_cycles == WAIT_CYCLES)
                    else value_mismatch("cycles in WAIT_FOR_CAM", cam_cycles, WAIT_CYCLES);
                assert (state == WAIT_FOR_NFRAME)
                    else fail_now("state did not move on to WAIT_FOR_NFRAME");
            end
            cam_cycles <= 0;
        end
    end

    always @(posedge clk_pixel) begin
        if (!rst && read_request) due_q.push_back(cycle + 3);
        if (!rst && read_valid) begin
            if (read_phase) begin
                assert (exp_q.size() != 0 && due_q.size() != 0)
                    else fail_now("read_valid with no read outstanding");
                assert (read_out == exp_q[0]) else value_mismatch("read_out", read_out, exp_q[0]);
                assert (cycle == due_q[0])
                    else fail_now("read_valid not 3 cycles after read_request");
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                capture_pulses <= capture_pulses + 1;
            end
        end
    end

    start_accept_a: assert property (@(posedge clk_pixel) disable iff (rst)
        (state == IDLE) |=> (state == ($past(start_calibration_step) ? WAIT_FOR_CAM : IDLE))
    ) else fail_now("IDLE did not follow the start input");

    nframe_step_a: assert property (@(posedge clk_pixel) disable iff (rst)
        (state == WAIT_FOR_NFRAME)
            |=> (state == ($past(new_frame_d) ? CAPTURE_FRAME : WAIT_FOR_NFRAME))
    ) else fail_now("WAIT_FOR_NFRAME did not end at a new frame");

    capture_step_a: assert property (@(posedge clk_pixel) disable iff (rst)
        (state == CAPTURE_FRAME) |=> (state == ($past(new_frame_d) ? IDLE : CAPTURE_FRAME))
    ) else fail_now("CAPTURE_FRAME did not end at a new frame");

    overwrite_set_a: assert property (@(posedge clk_pixel) disable iff (rst)
        (should_overwrite_latch && !(state == CAPTURE_FRAME && new_frame_d)) |=> should_overwrite
    ) else fail_now("should_overwrite not set after the latch pulse");

    overwrite_hold_a: assert property (@(posedge clk_pixel) disable iff (rst)
        (should_overwrite && state != CAPTURE_FRAME) |=> should_overwrite
    ) else fail_now("should_overwrite dropped outside a capture frame");

    overwrite_clear_a: assert property (@(posedge clk_pixel) disable iff (rst)
        (state == CAPTURE_FRAME && new_frame_d) |=> !should_overwrite
    ) else fail_now("should_overwrite still set after the capture frame");

    // **************************************************
    // main sequence
    // **************************************************
    initial begin
        void'($urandom(32'hdbef_4c5a));
        rst                    = 1'b1;
        luma                   = 8'd0;
        hcount_in              = 11'd0;
        vcount_in              = 10'd0;
        new_frame_in           = 1'b0;
        low_thresh             = `CALIB_LOW_THRESH;
        high_thresh            = `CALIB_HIGH_THRESH;
        start_calibration_step = 1'b0;
        should_overwrite_latch = 1'b0;
        read_request           = 1'b0;
        for (int b = 0; b < N_BLOCKS; b++) begin
            codes[b]      = 4'($urandom());
            gray_block[b] = (b % 7 == 3);
        end
        repeat (3) next_cycle();
        rst = 1'b0;

        assert (state == IDLE) else value_mismatch("state", state, IDLE);
        assert (!should_overwrite) else value_mismatch("should_overwrite", should_overwrite, 0);
        assert (!read_valid) else value_mismatch("read_valid", read_valid, 0);
        assert (wait_counter == '0) else value_mismatch("wait_counter", wait_counter, 0);

        should_overwrite_latch = 1'b1; // first step overwrites.
        next_cycle();
        should_overwrite_latch = 1'b0;
        assert (should_overwrite) else value_mismatch("should_overwrite", should_overwrite, 1);

        for (int step = 0; step < 4; step++) begin
            run_step(step);
            assert (!should_overwrite)
                else value_mismatch("should_overwrite", should_overwrite, 0);
        end

        read_phase = 1'b1;
        for (int b = 0; b < N_BLOCKS; b++) begin
            read_block(b);
        end
        while (exp_q.size() != 0) next_cycle();
        repeat (4) next_cycle(); // a late extra pulse has no read to match.

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/calib_pkg.sv
rtl/pixel_detect.sv
rtl/calibration_step_fsm.sv
rtl/shift_accum_ram.sv
rtl/calib_capture_top.sv
tests/tb_calib_capture.sv

//--- Makefile
TOP := tb_calib_capture

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o V$(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
